// File: verilog/mon_pkg.sv
//----------------------------------------------------------
// AXI4 read monitor shared definitions
// Bus widths, state and event encodings, record formats
//----------------------------------------------------------
`default_nettype none

package mon_pkg;

        // Bus widths
        localparam int ID_W   = 8;
        localparam int ADDR_W = 32;
        localparam int LEN_W  = 8;

        // Beat counts reach 256, one bit more than arlen
        typedef logic [LEN_W:0] beat_cnt_t;

        typedef enum logic [2:0] {
                st_addr,
                st_data,
                st_complete,
                st_error,
                st_orphan
        } trans_state_e;

        typedef enum logic [2:0] {
                evt_ok,
                evt_slverr,
                evt_decerr,
                evt_len_mismatch,
                evt_orphan
        } evt_code_e;

        //----------------------------------------------------------
        // Records
        //----------------------------------------------------------

        // One accepted read-address beat
        typedef struct packed {
                logic              valid;
                logic [ID_W-1:0]   id;
                logic [ADDR_W-1:0] addr;
                logic [LEN_W-1:0]  len;
        } ar_rec_t;

        // One accepted read-data beat
        typedef struct packed {
                logic            valid;
                logic [ID_W-1:0] id;
                logic [1:0]      resp;
                logic            last;
        } r_rec_t;

        // Report for one finished transaction
        typedef struct packed {
                logic [ID_W-1:0]   id;
                logic [ADDR_W-1:0] addr;
                beat_cnt_t         beats;
                evt_code_e         code;
        } evt_rec_t;

        // Outstanding transaction slot
        typedef struct packed {
                logic              valid;
                trans_state_e      state;
                logic [ID_W-1:0]   id;
                logic [ADDR_W-1:0] addr;
                beat_cnt_t         exp_beats;
                beat_cnt_t         beats;
                evt_code_e         code;
                logic              err_seen;
        } entry_t;

endpackage

`default_nettype wire

// File: verilog/axi_rd_capture.sv
//----------------------------------------------------------
// AXI4 read channel capture
// Registers each AR and R handshake as a one-cycle record
//----------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module axi_rd_capture
        import mon_pkg::*;
(
        input  wire logic              aclk,
        input  wire logic              arst_n,

        // Read-address channel
        input  wire logic              arvalid,
        input  wire logic              arready,
        input  wire logic [ID_W-1:0]   arid,
        input  wire logic [ADDR_W-1:0] araddr,
        input  wire logic [LEN_W-1:0]  arlen,

        // Read-data channel
        input  wire logic              rvalid,
        input  wire logic              rready,
        input  wire logic [ID_W-1:0]   rid,
        input  wire logic [1:0]        rresp,
        input  wire logic              rlast,

        output ar_rec_t                ar_rec,
        output r_rec_t                 r_rec
);

        logic              ar_hs;
        logic              r_hs;
        logic              ar_vld_q;
        logic              r_vld_q;
        logic [ID_W-1:0]   ar_id_q;
        logic [ADDR_W-1:0] ar_addr_q;
        logic [LEN_W-1:0]  ar_len_q;
        logic [ID_W-1:0]   r_id_q;
        logic [1:0]        r_resp_q;
        logic              r_last_q;

        assign ar_hs = arvalid && arready;
        assign r_hs  = rvalid && rready;

        // Valid flags pulse for one cycle per handshake
        always_ff @(posedge aclk or negedge arst_n) begin
                if (!arst_n) begin
                        ar_vld_q <= 1'b0;
                        r_vld_q  <= 1'b0;
                end else begin
                        ar_vld_q <= ar_hs;
                        r_vld_q  <= r_hs;
                end
        end

        always_ff @(posedge aclk) begin
                if (ar_hs) begin
                        ar_id_q   <= arid;
                        ar_addr_q <= araddr;
                        ar_len_q  <= arlen;
                end
                if (r_hs) begin
                        r_id_q   <= rid;
                        r_resp_q <= rresp;
                        r_last_q <= rlast;
                end
        end

        assign ar_rec = '{valid: ar_vld_q, id: ar_id_q, addr: ar_addr_q, len: ar_len_q};
        assign r_rec  = '{valid: r_vld_q, id: r_id_q, resp: r_resp_q, last: r_last_q};

endmodule

`default_nettype wire

// File: verilog/trans_table.sv
//----------------------------------------------------------
// Outstanding read transaction table
// Allocates, counts beats, checks length and frees slots
//----------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module trans_table
        import mon_pkg::*;
#(
        parameter int MAX_TRANS = 16
)
(
        input  wire logic                 aclk,
        input  wire logic                 arst_n,

        input  wire ar_rec_t              ar_rec,
        input  wire r_rec_t               r_rec,
        input  wire logic [MAX_TRANS-1:0] release_mask,

        output entry_t [MAX_TRANS-1:0]    entries,
        output logic [7:0]                active_count
);

        localparam int IDX_W = (MAX_TRANS > 1) ? $clog2(MAX_TRANS) : 1;

        entry_t [MAX_TRANS-1:0] tbl_q;

        logic             free1_found;
        logic             free2_found;
        logic [IDX_W-1:0] free1_idx;
        logic [IDX_W-1:0] free2_idx;
        logic             match_found;
        logic [IDX_W-1:0] match_idx;
        logic             orph_ok;
        logic [IDX_W-1:0] orph_idx;
        logic [7:0]       valid_cnt;

        entry_t           alloc_ent;
        entry_t           orph_ent;
        entry_t           upd_ent;

        //----------------------------------------------------------
        // Priority scans
        //----------------------------------------------------------

        // Two lowest free slots, so an address and an orphan beat
        // can both be placed in one cycle
        always_comb begin
                free1_found = 1'b0;
                free2_found = 1'b0;
                free1_idx   = '0;
                free2_idx   = '0;
                match_found = 1'b0;
                match_idx   = '0;
                valid_cnt   = '0;
                for (int i = 0; i < MAX_TRANS; i++) begin
                        if (!tbl_q[i].valid) begin
                                if (!free1_found) begin
                                        free1_found = 1'b1;
                                        free1_idx   = IDX_W'(i);
                                end else if (!free2_found) begin
                                        free2_found = 1'b1;
                                        free2_idx   = IDX_W'(i);
                                end
                        end
                        if (!match_found && tbl_q[i].valid && tbl_q[i].id == r_rec.id &&
                            (tbl_q[i].state == st_addr || tbl_q[i].state == st_data)) begin
                                match_found = 1'b1;
                                match_idx   = IDX_W'(i);
                        end
                        valid_cnt = valid_cnt + 8'(tbl_q[i].valid);
                end
        end

        // Orphan steps past the slot taken by a same-cycle address
        assign orph_ok  = ar_rec.valid ? free2_found : free1_found;
        assign orph_idx = ar_rec.valid ? free2_idx : free1_idx;

        //----------------------------------------------------------
        // Next entry contents
        //----------------------------------------------------------
        always_comb begin
                alloc_ent           = '0;
                alloc_ent.valid     = 1'b1;
                alloc_ent.state     = st_addr;
                alloc_ent.id        = ar_rec.id;
                alloc_ent.addr      = ar_rec.addr;
                alloc_ent.exp_beats = beat_cnt_t'(ar_rec.len) + beat_cnt_t'(1);
                alloc_ent.code      = evt_ok;

                orph_ent           = '0;
                orph_ent.valid     = 1'b1;
                orph_ent.state     = st_orphan;
                orph_ent.id        = r_rec.id;
                orph_ent.beats     = beat_cnt_t'(1);
                orph_ent.code      = evt_orphan;
        end

        // Beat update of the matched entry
        always_comb begin
                upd_ent       = tbl_q[match_idx];
                upd_ent.beats = upd_ent.beats + beat_cnt_t'(1);
                upd_ent.state = st_data;

                // Only the first error response is kept
                if (!upd_ent.err_seen && r_rec.resp[1]) begin
                        upd_ent.err_seen = 1'b1;
                        upd_ent.code     = r_rec.resp[0] ? evt_decerr : evt_slverr;
                end

                if (r_rec.last) begin
                        if (upd_ent.err_seen) begin
                                upd_ent.state = st_error;
                        end else if (upd_ent.beats != upd_ent.exp_beats) begin
                                upd_ent.state = st_error;
                                upd_ent.code  = evt_len_mismatch;
                        end else begin
                                upd_ent.state = st_complete;
                                upd_ent.code  = evt_ok;
                        end
                end
        end

        //----------------------------------------------------------
        // Table registers
        //----------------------------------------------------------
        always_ff @(posedge aclk or negedge arst_n) begin
                if (!arst_n) begin
                        tbl_q        <= '0;
                        active_count <= '0;
                end else begin
                        // A released slot is final, so no beat touches it here
                        for (int i = 0; i < MAX_TRANS; i++) begin
                                if (release_mask[i]) begin
                                        tbl_q[i].valid <= 1'b0;
                                end
                        end

                        if (ar_rec.valid && free1_found) begin
                                tbl_q[free1_idx] <= alloc_ent;
                        end

                        if (r_rec.valid) begin
                                if (match_found) begin
                                        tbl_q[match_idx] <= upd_ent;
                                end else if (orph_ok) begin
                                        tbl_q[orph_idx] <= orph_ent;
                                end
                        end

                        active_count <= valid_cnt;
                end
        end

        assign entries = tbl_q;

endmodule

`default_nettype wire

// File: verilog/event_reporter.sv
//----------------------------------------------------------
// Event reporter
// Presents finished entries as events and frees their slots
//----------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module event_reporter
        import mon_pkg::*;
#(
        parameter int MAX_TRANS = 16
)
(
        input  wire logic                   aclk,
        input  wire logic                   arst_n,

        input  wire entry_t [MAX_TRANS-1:0] entries,
        input  wire logic                   evt_ready,

        output logic                        evt_valid,
        output evt_rec_t                    evt,
        output logic [MAX_TRANS-1:0]        release_mask
);

        localparam int IDX_W = (MAX_TRANS > 1) ? $clog2(MAX_TRANS) : 1;

        typedef enum logic [1:0] {
                rpt_idle,
                rpt_send,
                rpt_gap
        } rpt_state_e;

        rpt_state_e             state_q;
        logic [IDX_W-1:0]       sel_q;
        logic                   done_found;
        logic [IDX_W-1:0]       done_idx;
        logic [MAX_TRANS-1:0]   sel_mask;
        logic                   load_evt;

        // Lowest slot holding a finished transaction
        always_comb begin
                done_found = 1'b0;
                done_idx   = '0;
                for (int i = 0; i < MAX_TRANS; i++) begin
                        if (!done_found && entries[i].valid &&
                            entries[i].state inside {st_complete, st_error, st_orphan}) begin
                                done_found = 1'b1;
                                done_idx   = IDX_W'(i);
                        end
                end
        end

        always_comb begin
                for (int i = 0; i < MAX_TRANS; i++) begin
                        sel_mask[i] = (sel_q == IDX_W'(i));
                end
        end

        // Event is loaded on the first send cycle
        assign load_evt = (state_q == rpt_send) && !evt_valid;

        //----------------------------------------------------------
        // Report FSM
        //----------------------------------------------------------
        always_ff @(posedge aclk or negedge arst_n) begin
                if (!arst_n) begin
                        state_q      <= rpt_idle;
                        sel_q        <= '0;
                        evt_valid    <= 1'b0;
                        release_mask <= '0;
                end else begin
                        release_mask <= '0;
                        case (state_q)
                                rpt_idle: begin
                                        if (done_found) begin
                                                sel_q   <= done_idx;
                                                state_q <= rpt_send;
                                        end
                                end
                                rpt_send: begin
                                        if (!evt_valid) begin
                                                evt_valid <= 1'b1;
                                        end else if (evt_ready) begin
                                                evt_valid    <= 1'b0;
                                                release_mask <= sel_mask;
                                                state_q      <= rpt_gap;
                                        end
                                end
                                // Slot is freed while we wait here
                                rpt_gap: begin
                                        state_q <= rpt_idle;
                                end
                                default: begin
                                        state_q <= rpt_idle;
                                end
                        endcase
                end
        end

        always_ff @(posedge aclk) begin
                if (load_evt) begin
                        evt.id    <= entries[sel_q].id;
                        evt.addr  <= entries[sel_q].addr;
                        evt.beats <= entries[sel_q].beats;
                        evt.code  <= entries[sel_q].code;
                end
        end

endmodule

`default_nettype wire

// File: verilog/axi_rd_monitor.sv
//----------------------------------------------------------
// AXI4 read monitor top level
// Capture, transaction table and event reporter
//----------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module axi_rd_monitor
        import mon_pkg::*;
#(
        parameter int MAX_TRANS = 16
)
(
        input  wire logic              aclk,
        input  wire logic              arst_n,

        // Observed read-address channel
        input  wire logic              arvalid,
        input  wire logic              arready,
        input  wire logic [ID_W-1:0]   arid,
        input  wire logic [ADDR_W-1:0] araddr,
        input  wire logic [LEN_W-1:0]  arlen,

        // Observed read-data channel
        input  wire logic              rvalid,
        input  wire logic              rready,
        input  wire logic [ID_W-1:0]   rid,
        input  wire logic [1:0]        rresp,
        input  wire logic              rlast,

        // Event port
        input  wire logic              evt_ready,
        output logic                   evt_valid,
        output evt_rec_t               evt,

        output logic [7:0]             active_count
);

        ar_rec_t                ar_rec;
        r_rec_t                 r_rec;
        entry_t [MAX_TRANS-1:0] entries;
        logic [MAX_TRANS-1:0]   release_mask;

        axi_rd_capture u_capture (
                .aclk    (aclk),
                .arst_n  (arst_n),
                .arvalid (arvalid),
                .arready (arready),
                .arid    (arid),
                .araddr  (araddr),
                .arlen   (arlen),
                .rvalid  (rvalid),
                .rready  (rready),
                .rid     (rid),
                .rresp   (rresp),
                .rlast   (rlast),
                .ar_rec  (ar_rec),
                .r_rec   (r_rec)
        );

        trans_table #(
                .MAX_TRANS (MAX_TRANS)
        ) u_table (
                .aclk         (aclk),
                .arst_n       (arst_n),
                .ar_rec       (ar_rec),
                .r_rec        (r_rec),
                .release_mask (release_mask),
                .entries      (entries),
                .active_count (active_count)
        );

        event_reporter #(
                .MAX_TRANS (MAX_TRANS)
        ) u_reporter (
                .aclk         (aclk),
                .arst_n       (arst_n),
                .entries      (entries),
                .evt_ready    (evt_ready),
                .evt_valid    (evt_valid),
                .evt          (evt),
                .release_mask (release_mask)
        );

endmodule

`default_nettype wire

// File: bench/tb_model.svh
//----------------------------------------------------------
// AXI4 read monitor testbench model
// Reference event function and read bus driving tasks
//----------------------------------------------------------
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

// Event the monitor should report for the beats driven on one id
function automatic evt_rec_t expected_event(input logic [ID_W-1:0] id,
        input logic [ADDR_W-1:0] addr, input int len, input bit tracked,
        input logic [1:0] resps[$]);
        evt_rec_t rec;
        bit       err;

        rec.id = id;
        if (!tracked) begin
                rec.addr  = '0;
                rec.beats = beat_cnt_t'(1);
                rec.code  = evt_orphan;
                return rec;
        end
        rec.addr  = addr;
        rec.beats = beat_cnt_t'(resps.size());
        rec.code  = evt_ok;
        err       = 1'b0;
        // First error response wins
        foreach (resps[i]) begin
                if (!err && resps[i] == 2'd2) begin
                        err      = 1'b1;
                        rec.code = evt_slverr;
                end else if (!err && resps[i] == 2'd3) begin
                        err      = 1'b1;
                        rec.code = evt_decerr;
                end
        end
        if (!err && resps.size() != len + 1) begin
                rec.code = evt_len_mismatch;
        end
        return rec;
endfunction

// One address beat, ready held low for a random stall first
task automatic send_ar(input logic [ID_W-1:0] id, input logic [ADDR_W-1:0] addr,
        input int len);
        int stall;

        stall = $random(bus_seed) & 3;
        @(negedge aclk);
        arvalid = 1'b1;
        arready = 1'b0;
        arid    = id;
        araddr  = addr;
        arlen   = LEN_W'(len);
        repeat (stall) @(negedge aclk);
        arready = 1'b1;
        @(negedge aclk);
        arvalid = 1'b0;
        arready = 1'b0;
endtask

// One data beat, same stall scheme
task automatic send_r(input logic [ID_W-1:0] id, input logic [1:0] resp, input logic last);
        int stall;

        stall = $random(bus_seed) & 3;
        @(negedge aclk);
        rvalid = 1'b1;
        rready = 1'b0;
        rid    = id;
        rresp  = resp;
        rlast  = last;
        repeat (stall) @(negedge aclk);
        rready = 1'b1;
        @(negedge aclk);
        rvalid = 1'b0;
        rready = 1'b0;
endtask

// Full burst: expectation first, then address and all data beats
task automatic run_burst(input logic [ID_W-1:0] id, input logic [ADDR_W-1:0] addr,
        input int len, input logic [1:0] resps[$]);
        exp_q.push_back(expected_event(id, addr, len, 1'b1, resps));
        send_ar(id, addr, len);
        for (int i = 0; i < resps.size(); i++) begin
                send_r(id, resps[i], i == resps.size() - 1);
        end
endtask

`endif

// File: bench/tb_axi_rd_monitor.sv
//----------------------------------------------------------
// AXI4 read monitor testbench
// Drives read bursts, scores reported events against a model
//----------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module tb_axi_rd_monitor
        import mon_pkg::*;
;

        localparam int MAX_TRANS      = 16;
        localparam int N_MULTI        = 6;
        // Bursts, error and length cases, orphan, full table and its orphans
        localparam int NUM_TRANS      = 1 + N_MULTI + 2 + 2 + 1 + (MAX_TRANS + 1) + 2;
        localparam int TIMEOUT_CYCLES = 200 * NUM_TRANS + 500;

        logic              aclk = 1'b0;
        logic              arst_n;
        logic              arvalid;
        logic              arready;
        logic [ID_W-1:0]   arid;
        logic [ADDR_W-1:0] araddr;
        logic [LEN_W-1:0]  arlen;
        logic              rvalid;
        logic              rready;
        logic [ID_W-1:0]   rid;
        logic [1:0]        rresp;
        logic              rlast;
        logic              evt_ready;
        logic              evt_valid;
        evt_rec_t          evt;
        logic [7:0]        active_count;

        integer            bus_seed   = 32'h1a6a;
        integer            ready_seed = 32'h1a6a;
        evt_rec_t          exp_q[$];
        string             test_name  = "reset";
        bit                stall_ready;
        int                ready_hold;

        `include "tb_model.svh"

        axi_rd_monitor #(
                .MAX_TRANS (MAX_TRANS)
        ) axi_rd_monitor_inst (.*);

        always #10 aclk = ~aclk;

        task automatic report_failure(input string msg);
                $display("%s", msg);
                $display(">>> FAIL");
        endtask

        task automatic check_value(input string what, input int expected, input int actual);
                assert (expected == actual) else begin
                        report_failure($sformatf("FAILED %s %s: expected %0d actual %0d",
                                test_name, what, expected, actual));
                        $fatal(1, "value mismatch");
                end
        endtask

        function automatic int find_expected(input logic [ID_W-1:0] id);
                foreach (exp_q[i]) begin
                        if (exp_q[i].id == id) begin
                                return i;
                        end
                end
                return -1;
        endfunction

        task automatic wait_events();
                while (exp_q.size() != 0) @(negedge aclk);
        endtask

        // Slot release and count update take a few cycles after acceptance
        task automatic wait_idle();
                for (int i = 0; i < 20 && active_count != 8'd0; i++) begin
                        @(negedge aclk);
                end
                check_value("active count", 0, int'(active_count));
        endtask

        // Random low stretches on evt_ready while stalling is enabled
        always @(negedge aclk) begin
                if (!stall_ready) begin
                        evt_ready  = 1'b1;
                        ready_hold = 0;
                end else if (ready_hold == 0) begin
                        evt_ready  = ~evt_ready;
                        ready_hold = 1 + ($random(ready_seed) & 7);
                end else begin
                        ready_hold = ready_hold - 1;
                end
        end

        //----------------------------------------------------------
        // Scoreboard compare on every accepted event
        //----------------------------------------------------------
        always @(posedge aclk) begin
                int idx;

                if (arst_n && evt_valid && evt_ready) begin
                        idx = find_expected(evt.id);
                        assert (idx >= 0) else begin
                                report_failure($sformatf("%s: event for id %h was not expected",
                                        test_name, evt.id));
                                $fatal(1, "unexpected event");
                        end
                        assert (evt == exp_q[idx]) else begin
                                report_failure($sformatf("FAILED %s: expected %h actual %h",
                                        test_name, exp_q[idx], evt));
                                $fatal(1, "event mismatch");
                        end
                        exp_q.delete(idx);
                end
        end

        initial begin
                repeat (TIMEOUT_CYCLES) @(posedge aclk);
                report_failure($sformatf("%s: timed out waiting for events", test_name));
                $fatal(1, "watchdog timeout");
        end

        initial begin
                logic [1:0] resps[$];
                int         rem[N_MULTI];
                int         lens[MAX_TRANS];
                bit         busy;

                arst_n      = 1'b0;
                arvalid     = 1'b0;
                arready     = 1'b0;
                arid        = '0;
                araddr      = '0;
                arlen       = '0;
                rvalid      = 1'b0;
                rready      = 1'b0;
                rid         = '0;
                rresp       = '0;
                rlast       = 1'b0;
                evt_ready   = 1'b1;
                stall_ready = 1'b0;
                repeat (16) @(posedge aclk);
                @(negedge aclk);
                arst_n = 1'b1;
                check_value("active count", 0, int'(active_count));

                test_name = "single burst";
                resps.delete();
                repeat (4) resps.push_back(2'd0);
                run_burst(8'h11, 32'h0000_4000, 3, resps);
                wait_events();
                wait_idle();

                // Interleaved beats across several live bursts
                test_name = "interleaved bursts";
                for (int i = 0; i < N_MULTI; i++) begin
                        rem[i] = 1 + ($random(bus_seed) & 7);
                        resps.delete();
                        repeat (rem[i]) resps.push_back(2'd0);
                        exp_q.push_back(expected_event(ID_W'(32'h20 + i),
                                ADDR_W'(32'h1000_0000 + i * 32'h100), rem[i] - 1, 1'b1, resps));
                        send_ar(ID_W'(32'h20 + i), ADDR_W'(32'h1000_0000 + i * 32'h100),
                                rem[i] - 1);
                end
                busy = 1'b1;
                while (busy) begin
                        busy = 1'b0;
                        for (int i = 0; i < N_MULTI; i++) begin
                                if (rem[i] > 0) begin
                                        send_r(ID_W'(32'h20 + i), 2'd0, rem[i] == 1);
                                        rem[i] = rem[i] - 1;
                                        busy   = 1'b1;
                                end
                        end
                end
                wait_events();
                wait_idle();

                test_name = "error responses";
                resps.delete();
                repeat (6) resps.push_back(2'd0);
                resps[2] = 2'd2;
                run_burst(8'h31, 32'h0000_8000, 5, resps);
                resps[2] = 2'd0;
                resps[3] = 2'd3;
                resps[4] = 2'd2;
                run_burst(8'h32, 32'h0000_9000, 5, resps);
                wait_events();
                wait_idle();

                // Last beat too early, then too late
                test_name = "length mismatch";
                resps.delete();
                repeat (3) resps.push_back(2'd0);
                run_burst(8'h41, 32'h0000_a000, 5, resps);
                resps.delete();
                repeat (4) resps.push_back(2'd0);
                run_burst(8'h42, 32'h0000_b000, 1, resps);
                wait_events();
                wait_idle();

                test_name = "orphan beat";
                exp_q.push_back(expected_event(8'h55, 32'hdead_0000, 0, 1'b0, resps));
                send_r(8'h55, 2'd0, 1'b1);
                wait_events();
                wait_idle();

                //----------------------------------------------------------
                // Full table under event back-pressure
                //----------------------------------------------------------
                test_name = "table full";
                for (int i = 0; i < MAX_TRANS; i++) begin
                        lens[i] = $random(bus_seed) & 3;
                        resps.delete();
                        repeat (lens[i] + 1) resps.push_back(2'd0);
                        exp_q.push_back(expected_event(ID_W'(32'h60 + i),
                                ADDR_W'(32'h8000_0000 + i * 32'h40), lens[i], 1'b1, resps));
                        send_ar(ID_W'(32'h60 + i), ADDR_W'(32'h8000_0000 + i * 32'h40), lens[i]);
                end
                // No free slot left, this command is dropped
                send_ar(8'h70, 32'h9000_0000, 1);
                repeat (2) @(negedge aclk);
                check_value("full count", MAX_TRANS, int'(active_count));
                stall_ready = 1'b1;
                for (int i = 0; i < MAX_TRANS; i++) begin
                        for (int b = 0; b <= lens[i]; b++) begin
                                send_r(ID_W'(32'h60 + i), 2'd0, b == lens[i]);
                        end
                end
                wait_events();
                // Beats of the dropped command now land in free slots
                resps.delete();
                exp_q.push_back(expected_event(8'h70, 32'h9000_0000, 1, 1'b0, resps));
                exp_q.push_back(expected_event(8'h70, 32'h9000_0000, 1, 1'b0, resps));
                send_r(8'h70, 2'd0, 1'b0);
                send_r(8'h70, 2'd0, 1'b1);
                wait_events();
                stall_ready = 1'b0;
                wait_idle();

                @(negedge aclk);
                if (exp_q.size() == 0) begin
                        $display(">>> PASS");
                        $finish;
                end else begin
                        report_failure("expected events were never reported");
                        $fatal(1, "missing events");
                end
        end

endmodule

`default_nettype wire

// File: list.f
+incdir+bench
verilog/mon_pkg.sv
verilog/axi_rd_capture.sv
verilog/trans_table.sv
verilog/event_reporter.sv
verilog/axi_rd_monitor.sv
bench/tb_axi_rd_monitor.sv

// File: run.sh
#!/bin/sh
# Build and run the AXI4 read monitor testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
        --top-module tb_axi_rd_monitor \
        -f list.f \
        -o tb_axi_rd_monitor

./obj_dir/tb_axi_rd_monitor
